/* hdl/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    // Work RAM is 2 KB mirrored four times below 2000
    localparam logic [15:0] ram_mirror_mask = 16'h07FF;

    // Program ROM is 16 KB mirrored twice above 8000
    localparam logic [15:0] rom_mirror_mask = 16'h3FFF;

    // Nibbles 2 and 3 share the upper three bits
    localparam logic [3:0] ppu_window_hi = 4'h2;

    localparam logic [15:0] oamdma_addr = 16'h4014;

    localparam int vram_depth = 2048;
    localparam int oam_depth = 256;

    // Order follows the low three address bits in the window
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_t;

    // One CPU bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  w_data;
        logic        write;
    } bus_req_t;

    // Picture register access with strobes already qualified
    typedef struct packed {
        reg_t       sel;
        logic       rd;
        logic       wr;
        logic [7:0] data;
    } ppu_req_t;

endpackage : cpu_bus_pkg

/* hdl/cpu_ucode_pkg.sv */
package cpu_ucode_pkg;

    // Interrupt and reset vector bytes
    localparam logic [7:0] brk_vec_lo = 8'hFE;
    localparam logic [7:0] brk_vec_hi = 8'hFF;
    localparam logic [7:0] nmi_vec_lo = 8'hFA;
    localparam logic [7:0] nmi_vec_hi = 8'hFB;
    localparam logic [7:0] rst_vec_lo = 8'hFC;
    localparam logic [7:0] rst_vec_hi = 8'hFD;
    localparam logic [7:0] vec_page = 8'hFF;
    localparam logic [7:0] stack_page = 8'h01;

    // Status byte layout NV-BDIZC
    localparam int status_unused_bit = 5;
    localparam int status_break_bit = 4;

    typedef enum logic [1:0] {
        STATE_FETCH,
        STATE_DECODE,
        STATE_NEITHER
    } processor_state_t;

    typedef enum logic [3:0] {
        ADDRLO_BRKLO,
        ADDRLO_BRKHI,
        ADDRLO_FD,
        ADDRLO_FC,
        ADDRLO_PCLO,
        ADDRLO_RMEMBUFFER,
        ADDRLO_RMEM,
        ADDRLO_ALUOUT,
        ADDRLO_SP,
        ADDRLO_HOLD
    } addr_lo_src_t;

    typedef enum logic [2:0] {
        ADDRHI_1,
        ADDRHI_0,
        ADDRHI_FF,
        ADDRHI_PCHI,
        ADDRHI_RMEM,
        ADDRHI_ALUOUT,
        ADDRHI_HOLD
    } addr_hi_src_t;

    typedef enum logic [1:0] {
        ACCESS_READ,
        ACCESS_WRITE,
        ACCESS_NONE
    } access_t;

    typedef enum logic [3:0] {
        WMEM_PCHI,
        WMEM_PCLO,
        WMEM_STATUS_BRK,
        WMEM_STATUS_BC,
        WMEM_STORE_A,
        WMEM_STORE_X,
        WMEM_STORE_Y,
        WMEM_STORE_STATUS,
        WMEM_RMEM,
        WMEM_ALUOUT
    } wmem_src_t;

    typedef struct packed {
        processor_state_t state;
        addr_lo_src_t     addr_lo_src;
        addr_hi_src_t     addr_hi_src;
        access_t          access;
        wmem_src_t        wmem_src;
        logic             pchi_from_rmem;
    } bus_op_t;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  sp;
        logic [15:0] pc;
        logic        n;
        logic        v;
        logic        d;
        logic        i;
        logic        z;
        logic        c;
        logic [7:0]  alu_out;
    } cpu_regs_t;

endpackage : cpu_ucode_pkg

/* hdl/cpu_bus_driver.sv */
`timescale 1ns/100ps

module cpu_bus_driver import cpu_bus_pkg::*; import cpu_ucode_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      clock_en,
    input  bus_op_t   op,
    input  cpu_regs_t regs,
    input  logic      nmi_active,
    input  logic [7:0] r_data,
    output bus_req_t  bus
);

    logic [7:0]  r_data_buffer;
    logic [15:0] held_addr;
    logic [15:0] addr;
    logic [7:0]  addr_lo;
    logic [7:0]  addr_hi;
    logic        lo_en;
    logic        hi_en;
    logic [7:0]  status_base;
    logic [7:0]  w_data;

    // Byte sources per micro-op
    always_comb begin
        addr_lo = 8'h00;
        addr_hi = 8'h00;
        lo_en = 1'b1;
        hi_en = 1'b1;
        if (op.state == STATE_NEITHER) begin
            case (op.addr_lo_src)
                ADDRLO_BRKLO:      addr_lo = nmi_active ? nmi_vec_lo : brk_vec_lo;
                ADDRLO_BRKHI:      addr_lo = nmi_active ? nmi_vec_hi : brk_vec_hi;
                ADDRLO_FD:         addr_lo = rst_vec_hi;
                ADDRLO_FC:         addr_lo = rst_vec_lo;
                ADDRLO_PCLO:       addr_lo = regs.pc[7:0];
                ADDRLO_RMEMBUFFER: addr_lo = r_data_buffer;
                ADDRLO_RMEM:       addr_lo = r_data;
                ADDRLO_ALUOUT:     addr_lo = regs.alu_out;
                ADDRLO_SP:         addr_lo = regs.sp;
                default:           lo_en = 1'b0;
            endcase
            case (op.addr_hi_src)
                ADDRHI_1:      addr_hi = stack_page;
                ADDRHI_0:      addr_hi = 8'h00;
                ADDRHI_FF:     addr_hi = vec_page;
                ADDRHI_PCHI:   addr_hi = regs.pc[15:8];
                ADDRHI_RMEM:   addr_hi = r_data;
                ADDRHI_ALUOUT: addr_hi = regs.alu_out;
                default:       hi_en = 1'b0;
            endcase
        end else begin
            // Opcode and operand fetch run off the PC
            addr_lo = regs.pc[7:0];
            addr_hi = op.pchi_from_rmem ? r_data : regs.pc[15:8];
        end
    end

    // Held bytes show through where a selector says HOLD
    assign addr = {hi_en ? addr_hi : held_addr[15:8], lo_en ? addr_lo : held_addr[7:0]};

    always_comb begin
        status_base = {regs.n, regs.v, 2'b00, regs.d, regs.i, regs.z, regs.c};
        status_base[status_unused_bit] = 1'b1;
    end

    always_comb begin
        w_data = status_base;
        case (op.wmem_src)
            WMEM_PCHI:         w_data = regs.pc[15:8];
            WMEM_PCLO:         w_data = regs.pc[7:0];
            // B is clear when the push comes from NMI
            WMEM_STATUS_BRK:   w_data[status_break_bit] = !nmi_active;
            WMEM_STATUS_BC:    w_data[status_break_bit] = 1'b0;
            WMEM_STORE_A:      w_data = regs.a;
            WMEM_STORE_X:      w_data = regs.x;
            WMEM_STORE_Y:      w_data = regs.y;
            WMEM_STORE_STATUS: w_data[status_break_bit] = 1'b1;
            WMEM_RMEM:         w_data = r_data;
            WMEM_ALUOUT:       w_data = regs.alu_out;
            default:           w_data = 8'h00;
        endcase
    end

    assign bus = '{addr: addr, w_data: w_data, write: op.access == ACCESS_WRITE};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            held_addr <= 16'h0000;
            r_data_buffer <= 8'h00;
        end else if (clock_en) begin
            held_addr <= addr;
            r_data_buffer <= r_data;
        end
    end

    state_known: assert property (
        @(posedge clock) disable iff (!reset_n) clock_en |-> !$isunknown(op.state)
    );

endmodule : cpu_bus_driver

/* hdl/cpu_memory_map.sv */
`timescale 1ns/100ps

module cpu_memory_map import cpu_bus_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       clock_en,
    input  bus_req_t   bus,
    output ppu_req_t   ppu,
    input  logic [7:0] ppu_rd_data,
    output logic [7:0] r_data
);

    logic [7:0] ram [0:ram_mirror_mask];
    logic [7:0] rom [0:rom_mirror_mask];

    logic [10:0] ram_index;
    logic [13:0] rom_index;
    logic        ram_hit;
    logic        window_hit;
    logic        dma_hit;
    logic        rom_hit;
    logic        reg_hit;
    logic        read_cycle;
    logic        reg_read_q;
    logic [7:0]  mem_rd_q;

    initial begin
        $readmemh("hdl/prg_rom.hex", rom);
    end

    assign ram_index = 11'(bus.addr & ram_mirror_mask);
    assign rom_index = 14'(bus.addr & rom_mirror_mask);

    // Address decode
    assign ram_hit = bus.addr[15:13] == 3'b000;
    assign window_hit = bus.addr[15:13] == ppu_window_hi[3:1];
    assign dma_hit = bus.addr == oamdma_addr;
    assign rom_hit = bus.addr[15];
    assign reg_hit = window_hit || dma_hit;

    assign read_cycle = clock_en && !bus.write;

    always_comb begin
        ppu.sel = reg_t'({1'b0, bus.addr[2:0]});
        if (dma_hit) begin
            ppu.sel = OAMDMA;
        end
        ppu.rd = read_cycle && reg_hit;
        ppu.wr = clock_en && bus.write && reg_hit;
        ppu.data = bus.w_data;
    end

    // Unmapped and I/O reads come back as zero
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_rd_q <= 8'h00;
            reg_read_q <= 1'b0;
        end else if (read_cycle) begin
            reg_read_q <= reg_hit;
            if (ram_hit) begin
                mem_rd_q <= ram[ram_index];
            end else if (rom_hit) begin
                mem_rd_q <= rom[rom_index];
            end else begin
                mem_rd_q <= 8'h00;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (clock_en && bus.write && ram_hit) begin
            ram[ram_index] <= bus.w_data;
        end
    end

    assign r_data = reg_read_q ? ppu_rd_data : mem_rd_q;

    ppu_strobes_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(ppu.rd && ppu.wr)
    );

endmodule : cpu_memory_map

/* hdl/ppu_register_port.sv */
`timescale 1ns/100ps

module ppu_register_port import cpu_bus_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  ppu_req_t   ppu,
    input  logic       vblank_start,
    output logic [7:0] ppu_rd_data
);

    localparam int vram_aw = $clog2(vram_depth);

    logic [7:0] vram [0:vram_depth-1];
    logic [7:0] oam [0:oam_depth-1];

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic [7:0]  oam_addr;
    logic [7:0]  dma_page;
    logic        write_toggle;
    logic        vblank;
    logic [13:0] vram_addr;
    logic [13:0] vram_step;
    logic [vram_aw-1:0] vram_index;
    logic [7:0]  read_buffer;
    logic [7:0]  rd_data;

    // PPUCTRL bit 2 picks column stepping
    assign vram_step = ppuctrl[2] ? 14'd32 : 14'd1;
    assign vram_index = vram_addr[vram_aw-1:0];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ppuctrl <= 8'h00;
            ppumask <= 8'h00;
            oam_addr <= 8'h00;
            dma_page <= 8'h00;
            write_toggle <= 1'b0;
            vblank <= 1'b0;
            vram_addr <= 14'h0000;
            read_buffer <= 8'h00;
            rd_data <= 8'h00;
        end else begin
            if (ppu.wr) begin
                case (ppu.sel)
                    PPUCTRL:   ppuctrl <= ppu.data;
                    PPUMASK:   ppumask <= ppu.data;
                    OAMADDR:   oam_addr <= ppu.data;
                    OAMDATA:   oam_addr <= oam_addr + 8'd1;
                    PPUSCROLL: write_toggle <= !write_toggle;
                    PPUADDR: begin
                        // High byte first, then low
                        if (!write_toggle) begin
                            vram_addr[13:8] <= ppu.data[5:0];
                        end else begin
                            vram_addr[7:0] <= ppu.data;
                        end
                        write_toggle <= !write_toggle;
                    end
                    PPUDATA:   vram_addr <= vram_addr + vram_step;
                    OAMDMA:    dma_page <= ppu.data;
                    default:   ;
                endcase
            end
            if (ppu.rd) begin
                case (ppu.sel)
                    PPUSTATUS: begin
                        // Bit 0 reports the address latch phase
                        rd_data <= {vblank, 6'b000000, write_toggle};
                        vblank <= 1'b0;
                        write_toggle <= 1'b0;
                    end
                    OAMDATA:   rd_data <= oam[oam_addr];
                    PPUDATA: begin
                        rd_data <= read_buffer;
                        read_buffer <= vram[vram_index];
                        vram_addr <= vram_addr + vram_step;
                    end
                    default:   rd_data <= 8'h00;
                endcase
            end
            if (vblank_start) begin
                vblank <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ppu.wr && ppu.sel == PPUDATA) begin
            vram[vram_index] <= ppu.data;
        end
        if (ppu.wr && ppu.sel == OAMDATA) begin
            oam[oam_addr] <= ppu.data;
        end
    end

    assign ppu_rd_data = rd_data;

    no_addr_write_on_read: assert property (
        @(posedge clock) disable iff (!reset_n) !(ppu.wr && ppu.sel == PPUADDR && ppu.rd)
    );

endmodule : ppu_register_port

/* hdl/cpu_mem_top.sv */
`timescale 1ns/100ps

module cpu_mem_top import cpu_bus_pkg::*; import cpu_ucode_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       clock_en,
    input  bus_op_t    op,
    input  cpu_regs_t  regs,
    input  logic       nmi_active,
    input  logic       vblank_start,
    output bus_req_t   bus,
    output logic [7:0] r_data
);

    ppu_req_t   ppu;
    logic [7:0] ppu_rd_data;

    cpu_bus_driver driver (
        .clock      (clock),
        .reset_n    (reset_n),
        .clock_en   (clock_en),
        .op         (op),
        .regs       (regs),
        .nmi_active (nmi_active),
        .r_data     (r_data),
        .bus        (bus)
    );

    cpu_memory_map memory_map (
        .clock       (clock),
        .reset_n     (reset_n),
        .clock_en    (clock_en),
        .bus         (bus),
        .ppu         (ppu),
        .ppu_rd_data (ppu_rd_data),
        .r_data      (r_data)
    );

    ppu_register_port ppu_port (
        .clock        (clock),
        .reset_n      (reset_n),
        .ppu          (ppu),
        .vblank_start (vblank_start),
        .ppu_rd_data  (ppu_rd_data)
    );

endmodule : cpu_mem_top

/* verification/cpu_mem_tb.sv */
`timescale 1ns/100ps

module cpu_mem_tb import cpu_bus_pkg::*; import cpu_ucode_pkg::*; ();

    localparam int max_rows = 256;
    localparam int num_cols = 22;

    logic       clock;
    logic       reset_n;
    logic       clock_en;
    bus_op_t    op;
    cpu_regs_t  regs;
    logic       nmi_active;
    logic       vblank_start;
    bus_req_t   bus;
    logic [7:0] r_data;

    // Columns after the name in file order
    string       names [0:max_rows-1];
    logic [15:0] rows [0:max_rows-1][0:num_cols-1];
    int          row_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    cpu_mem_top uut (
        .clock        (clock),
        .reset_n      (reset_n),
        .clock_en     (clock_en),
        .op           (op),
        .regs         (regs),
        .nmi_active   (nmi_active),
        .vblank_start (vblank_start),
        .bus          (bus),
        .r_data       (r_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string test, input string field,
                           input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s %s expected %h actual %h",
                               test, field, expected, actual));
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [15:0] f [0:num_cols-1];
        fd = $fopen("verification/cpu_mem_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the test file verification/cpu_mem_tests.txt");
        end else begin
            while (!$feof(fd) && row_count < max_rows) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                    f[19], f[20], f[21]);
                if (n != num_cols + 1) begin
                    fail_run($sformatf("Cannot parse test line: %s", line));
                end else begin
                    names[row_count] = name;
                    for (int k = 0; k < num_cols; k++) begin
                        rows[row_count][k] = f[k];
                    end
                    row_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_row(input int i);
        clock_en = rows[i][0][0];
        op.state = processor_state_t'(rows[i][1][1:0]);
        op.addr_lo_src = addr_lo_src_t'(rows[i][2][3:0]);
        op.addr_hi_src = addr_hi_src_t'(rows[i][3][2:0]);
        op.access = access_t'(rows[i][4][1:0]);
        op.wmem_src = wmem_src_t'(rows[i][5][3:0]);
        op.pchi_from_rmem = rows[i][6][0];
        regs.a = rows[i][7][7:0];
        regs.x = rows[i][8][7:0];
        regs.y = rows[i][9][7:0];
        // Don't-care rows get random A, X and Y
        if (rows[i][16][0]) begin
            regs.a = 8'($urandom);
            regs.x = 8'($urandom);
            regs.y = 8'($urandom);
        end
        regs.sp = rows[i][10][7:0];
        regs.pc = rows[i][11];
        {regs.n, regs.v, regs.d, regs.i, regs.z, regs.c} = rows[i][12][5:0];
        regs.alu_out = rows[i][13][7:0];
        nmi_active = rows[i][14][0];
        vblank_start = rows[i][15][0];
    endtask

    task automatic check_bus(input int i);
        compare(names[i], "addr", rows[i][17], bus.addr);
        compare(names[i], "write", rows[i][19], {15'h0000, bus.write});
        if (rows[i][19][0]) begin
            compare(names[i], "w_data", rows[i][18], {8'h00, bus.w_data});
        end
    endtask

    initial begin
        void'($urandom(32'h3e3f));
        reset_n = 1'b0;
        clock_en = 1'b0;
        op = '0;
        regs = '0;
        nmi_active = 1'b0;
        vblank_start = 1'b0;
        load_tests();
        cycle_limit = row_count * 4 + 50;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        compare("after_reset", "r_data", 16'h0000, {8'h00, r_data});
        for (int i = 0; i < row_count; i++) begin
            @(negedge clock);
            if (i > 0 && rows[i-1][21][0]) begin
                compare(names[i-1], "r_data", rows[i-1][20], {8'h00, r_data});
            end
            drive_row(i);
            #25;
            check_bus(i);
        end
        @(negedge clock);
        if (row_count > 0 && rows[row_count-1][21][0]) begin
            compare(names[row_count-1], "r_data", rows[row_count-1][20], {8'h00, r_data});
        end
        clock_en = 1'b0;
        vblank_start = 1'b0;
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : cpu_mem_tb

/* vlog.f */
hdl/cpu_bus_pkg.sv
hdl/cpu_ucode_pkg.sv
hdl/cpu_bus_driver.sv
hdl/cpu_memory_map.sv
hdl/ppu_register_port.sv
hdl/cpu_mem_top.sv
verification/cpu_mem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU memory-side testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cpu_mem_tb -o cpu_mem_sim

status=0
output=$(./obj_dir/cpu_mem_sim) || status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

/* hdl/prg_rom.hex */
// Program ROM image, one byte per line from offset 0010
@0010
A9
42
8D
05
00
4C
10
80
EA
EA
60
00
FF
5A

/* verification/cpu_mem_tests.txt */
# name ce state lo hi access wmem pchi a x y sp pc flags alu nmi vblank rnd
#   then expected: addr w_data write r_data r_check (w_data compared on writes only)
ram_write_0005      1 2 7 1 1 4 0 5C 22 33 FD 8010 00 05 0 0 0 0005 5C 1 00 0
ram_read_0805       1 2 8 5 0 4 0 11 22 33 05 8010 00 08 0 0 1 0805 00 0 5C 1
rom_read_8010       1 0 4 3 0 4 0 11 22 33 FD 8010 00 00 0 0 1 8010 00 0 A9 1
rom_read_c010       1 0 4 3 0 4 0 11 22 33 FD C010 00 00 0 0 1 C010 00 0 A9 1
rom_write_8010      1 2 4 3 1 5 0 11 77 33 FD 8010 00 00 0 0 0 8010 77 1 00 0
rom_read_after_wr   1 0 4 3 0 4 0 11 22 33 FD 8010 00 00 0 0 1 8010 00 0 A9 1
idle_no_enable      0 0 4 3 0 4 0 11 22 33 FD 8012 00 00 0 0 1 8012 00 0 A9 1
fetch_pc            1 0 4 3 0 4 0 11 22 33 FD 8017 00 00 0 0 1 8017 00 0 80 1
decode_pchi_rmem    1 1 4 3 0 4 1 11 22 33 FD 4411 00 00 0 0 1 8011 00 0 42 1
push_pchi           1 2 8 0 1 0 0 11 22 33 FD 8123 00 00 0 0 0 01FD 81 1 00 0
push_pclo           1 2 8 0 1 1 0 11 22 33 FC 8123 00 00 0 0 0 01FC 23 1 00 0
push_status_brk     1 2 8 0 1 2 0 11 22 33 FB 8010 21 00 0 0 0 01FB B1 1 00 0
push_status_nmi     1 2 8 0 1 2 0 11 22 33 FA 8010 21 00 1 0 0 01FA A1 1 00 0
push_status_bc      1 2 8 0 1 3 0 11 22 33 F9 8010 12 00 0 0 0 01F9 62 1 00 0
push_status_php     1 2 8 0 1 7 0 11 22 33 F8 8010 0C 00 0 0 0 01F8 3C 1 00 0
pull_status         1 2 8 0 0 4 0 11 22 33 FB 8010 00 00 0 0 1 01FB 00 0 B1 1
brk_vector_lo       1 2 0 2 1 9 0 11 22 33 FD 8010 00 00 0 0 0 FFFE 00 1 00 0
brk_vector_hi       1 2 1 2 1 9 0 11 22 33 FD 8010 00 00 0 0 0 FFFF 00 1 00 0
nmi_vector_lo       1 2 0 2 1 9 0 11 22 33 FD 8010 00 00 1 0 0 FFFA 00 1 00 0
nmi_vector_hi       1 2 1 2 1 9 0 11 22 33 FD 8010 00 00 1 0 0 FFFB 00 1 00 0
hold_high_byte      1 2 7 6 1 6 0 11 22 99 FD 8010 00 34 0 0 0 FF34 99 1 00 0
hold_low_byte       1 2 9 5 1 4 0 C3 22 33 FD 8010 00 00 0 0 0 0034 C3 1 00 0
alu_read_0034       1 2 7 1 0 4 0 11 22 33 FD 8010 00 34 0 0 1 0034 00 0 C3 1
rmem_low_byte       1 2 6 1 1 9 0 11 22 33 FD 8010 00 5E 0 0 0 00C3 5E 1 00 0
rmembuffer_low      1 2 5 1 0 4 0 11 22 33 FD 8010 00 00 0 0 1 00C3 00 0 5E 1
rmem_high_unmapped  1 2 7 4 2 4 0 11 22 33 FD 8010 00 34 0 0 1 5E34 00 0 00 1
ppuctrl_mirror_vbl  1 2 4 3 1 4 0 00 22 33 FD 3FF8 00 00 0 1 0 3FF8 00 1 00 0
status_vblank_set   1 2 4 3 0 4 0 11 22 33 FD 2002 00 00 0 0 1 2002 00 0 80 1
status_vblank_clear 1 2 4 3 0 4 0 11 22 33 FD 3FFA 00 00 0 0 1 3FFA 00 0 00 1
ppuaddr_high        1 2 4 3 1 4 0 21 22 33 FD 2006 00 00 0 0 0 2006 21 1 00 0
ppuaddr_low         1 2 4 3 1 4 0 08 22 33 FD 3FFE 00 00 0 0 0 3FFE 08 1 00 0
ppudata_write_1     1 2 4 3 1 4 0 A1 22 33 FD 2007 00 00 0 0 0 2007 A1 1 00 0
ppudata_write_2     1 2 4 3 1 4 0 B2 22 33 FD 2007 00 00 0 0 0 2007 B2 1 00 0
ppuctrl_inc32       1 2 4 3 1 4 0 04 22 33 FD 2000 00 00 0 0 0 2000 04 1 00 0
ppudata_write_3     1 2 4 3 1 4 0 C3 22 33 FD 2007 00 00 0 0 0 2007 C3 1 00 0
ppudata_write_4     1 2 4 3 1 4 0 D4 22 33 FD 2007 00 00 0 0 0 2007 D4 1 00 0
ppuctrl_inc1        1 2 4 3 1 4 0 00 22 33 FD 2000 00 00 0 0 0 2000 00 1 00 0
ppuaddr_high_2      1 2 4 3 1 4 0 21 22 33 FD 2006 00 00 0 0 0 2006 21 1 00 0
ppuaddr_low_2       1 2 4 3 1 4 0 08 22 33 FD 2006 00 00 0 0 0 2006 08 1 00 0
ppudata_read_stale  1 2 4 3 0 4 0 11 22 33 FD 2007 00 00 0 0 1 2007 00 0 00 1
ppudata_read_1      1 2 4 3 0 4 0 11 22 33 FD 2007 00 00 0 0 1 2007 00 0 A1 1
ppudata_read_2      1 2 4 3 0 4 0 11 22 33 FD 2007 00 00 0 0 1 2007 00 0 B2 1
ppuctrl_inc32_2     1 2 4 3 1 4 0 04 22 33 FD 2000 00 00 0 0 0 2000 04 1 00 0
ppuaddr_high_3      1 2 4 3 1 4 0 21 22 33 FD 2006 00 00 0 0 0 2006 21 1 00 0
ppuaddr_low_3       1 2 4 3 1 4 0 0A 22 33 FD 2006 00 00 0 0 0 2006 0A 1 00 0
ppudata_read_3      1 2 4 3 0 4 0 11 22 33 FD 2007 00 00 0 0 1 2007 00 0 C3 1
ppudata_read_4      1 2 4 3 0 4 0 11 22 33 FD 2007 00 00 0 0 1 2007 00 0 C3 1
ppudata_read_5      1 2 4 3 0 4 0 11 22 33 FD 2007 00 00 0 0 1 2007 00 0 D4 1
oamaddr_write       1 2 4 3 1 4 0 10 22 33 FD 2003 00 00 0 0 0 2003 10 1 00 0
oamdata_write       1 2 4 3 1 4 0 77 22 33 FD 2004 00 00 0 0 0 2004 77 1 00 0
oamaddr_rewrite     1 2 4 3 1 4 0 10 22 33 FD 2003 00 00 0 0 0 2003 10 1 00 0
oamdata_read        1 2 4 3 0 4 0 11 22 33 FD 2004 00 00 0 0 1 2004 00 0 77 1
oamdma_page         1 2 4 3 1 4 0 02 22 33 FD 4014 00 00 0 0 0 4014 02 1 00 0
ctrl_read_zero      1 2 4 3 0 4 0 11 22 33 FD 2000 00 00 0 0 1 2000 00 0 00 1
ram_mirror_again    1 2 8 5 0 4 0 11 22 33 05 8010 00 18 0 0 1 1805 00 0 5C 1
